// ==== src/sync_pkg.sv ====
package sync_pkg;

    // sample stream and scaled-down numerology
    localparam int IN_DW = 32;
    localparam int FFT_LEN = 16;
    localparam int CP1_LEN = 4;
    localparam int CP2_LEN = 2;
    localparam int SYM_PER_SF = 14;
    localparam int SUBFRAMES_PER_FRAME = 20;
    localparam int SFN_MAX = 1024;
    // two long-CP symbols plus twelve short-CP symbols per subframe
    localparam int SF_SAMPLES = 2 * (FFT_LEN + CP1_LEN) + (SYM_PER_SF - 2) * (FFT_LEN + CP2_LEN);
    localparam int FRAME_SAMPLES = SF_SAMPLES * SUBFRAMES_PER_FRAME;
    localparam int SYMS_BTWN_SSB = SUBFRAMES_PER_FRAME * SYM_PER_SF;

    // tuser field widths, sfn sits in the upper bits
    localparam int SFN_W = 10;
    localparam int SF_W = 5;
    localparam int SYM_W = 4;
    localparam int CP_W = 3;
    localparam int USER_W = SFN_W + SF_W + SYM_W + CP_W;

    // PSS detector
    localparam int NUM_NID2 = 3;
    localparam int PSS_LEN = 16;
    // stand-in sign patterns, a set bit means a negative real part
    localparam logic [PSS_LEN-1:0] PSS_PATTERN [NUM_NID2] = '{16'h3AD8, 16'hE153, 16'h569F};
    localparam int PSS_THRESHOLD = 15;
    localparam int METRIC_W = $clog2(PSS_LEN + 1);
    localparam int HOLD_W = $clog2(PSS_LEN + 1);

    // PSS mode timer, in clocks around the expected SSB
    localparam int PSS_EARLY = 8;
    localparam int PSS_LATE = 8;
    localparam int TMR_W = $clog2(FRAME_SAMPLES + PSS_LATE + 1);

    // timing FSM
    localparam int SMP_W = $clog2(FFT_LEN + CP1_LEN);
    localparam int SSB_CNT_W = $clog2(SYMS_BTWN_SSB + 1);
    // case A: the PSS occupies symbol 2, so detection marks the start of symbol 3
    localparam int PSS_SYM = 3;
    localparam int SSB_MISS_SMP = 3;

    typedef enum logic [1:0] {PSS_SEARCH, PSS_FIND, PSS_PAUSE} pss_mode_e;
    typedef enum logic [1:0] {WAIT_FOR_SSB, WAIT_FOR_IBAR, SYNCED} sync_state_e;

endpackage

// ==== src/pss_metric_if.sv ====
`timescale 1ns/1ps

interface pss_metric_if import sync_pkg::*; ();

    // one match metric lane per N_id_2
    logic [NUM_NID2-1:0][METRIC_W-1:0] metric;
    logic                              win_valid;
    pss_mode_e                         mode;
    logic [1:0]                        req_nid2;

    modport window (output win_valid);
    modport control (output mode, output req_nid2);
    modport select (input metric, input win_valid, input mode, input req_nid2);

endinterface

// ==== src/sample_window.sv ====
`timescale 1ns/1ps

module sample_window import sync_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [IN_DW-1:0]    s_axis_in_tdata_i,
    input  logic                s_axis_in_tvalid_i,
    output logic [PSS_LEN-1:0]  win_o,
    pss_metric_if.window        bus_o
);

    logic sign_bit;

    // I sits in the low half, so the real-part sign is its top bit
    assign sign_bit = s_axis_in_tdata_i[IN_DW/2-1];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            win_o <= '0;
            bus_o.win_valid <= 1'b0;
        end else begin
            bus_o.win_valid <= s_axis_in_tvalid_i;
            if (s_axis_in_tvalid_i) begin
                // oldest sample ends up in the MSB
                win_o <= {win_o[PSS_LEN-2:0], sign_bit};
            end
        end
    end

endmodule

// ==== src/pss_matcher.sv ====
`timescale 1ns/1ps

module pss_matcher import sync_pkg::*; #(
    parameter int NID2 = 0
) (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic [PSS_LEN-1:0]  win_i,
    output logic [METRIC_W-1:0] metric_o
);

    logic [PSS_LEN-1:0]  agree;
    logic [METRIC_W-1:0] count;

    // a set bit marks a position where the window sign matches the pattern
    assign agree = ~(win_i ^ PSS_PATTERN[NID2]);

    always_comb begin
        count = '0;
        for (int i = 0; i < PSS_LEN; i++) begin
            count = count + METRIC_W'(agree[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            metric_o <= '0;
        end else begin
            metric_o <= count;
        end
    end

    // the peak selector relies on the metric staying inside the pattern length
    metric_in_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni) metric_o <= METRIC_W'(PSS_LEN)
    );

endmodule

// ==== src/pss_peak_select.sv ====
`timescale 1ns/1ps

module pss_peak_select import sync_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_ni,
    pss_metric_if.select bus_i,
    output logic [1:0]   n_id_2_o,
    output logic         n_id_2_valid_o
);

    logic                cand_q;
    logic [HOLD_W-1:0]   holdoff_q;
    logic [METRIC_W-1:0] best_metric;
    logic [1:0]          best_idx;
    logic                fire;

    always_comb begin
        best_metric = '0;
        best_idx = '0;
        if (bus_i.mode == PSS_FIND) begin
            // only the lane of the cell we are already locked to counts
            if (32'(bus_i.req_nid2) < NUM_NID2) begin
                best_metric = bus_i.metric[bus_i.req_nid2];
                best_idx = bus_i.req_nid2;
            end
        end else begin
            // strict compare keeps the lowest index on ties
            for (int i = 0; i < NUM_NID2; i++) begin
                if (bus_i.metric[i] > best_metric) begin
                    best_metric = bus_i.metric[i];
                    best_idx = 2'(i);
                end
            end
        end
    end

    assign fire = cand_q && (holdoff_q == '0) && (bus_i.mode != PSS_PAUSE) &&
                  (best_metric >= METRIC_W'(PSS_THRESHOLD));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            cand_q <= 1'b0;
            holdoff_q <= '0;
            n_id_2_valid_o <= 1'b0;
        end else begin
            // metrics lag the window by one cycle
            cand_q <= bus_i.win_valid;
            n_id_2_valid_o <= fire;
            if (fire) begin
                holdoff_q <= HOLD_W'(PSS_LEN);
            end else if (cand_q && (holdoff_q != '0)) begin
                holdoff_q <= holdoff_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            n_id_2_o <= best_idx;
        end
    end

    no_adjacent_pulses: assert property (
        @(posedge clk_i) disable iff (!reset_ni) n_id_2_valid_o |=> !n_id_2_valid_o
    );

endmodule

// ==== src/frame_sync.sv ====
`timescale 1ns/1ps

module frame_sync import sync_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic [IN_DW-1:0]  s_axis_in_tdata_i,
    input  logic              s_axis_in_tvalid_i,
    input  logic [1:0]        n_id_2_i,
    input  logic              n_id_2_valid_i,
    input  logic [2:0]        ibar_ssb_i,
    input  logic              ibar_ssb_valid_i,
    pss_metric_if.control     ctrl_o,
    output logic [IN_DW-1:0]  m_axis_out_tdata_o,
    output logic [USER_W-1:0] m_axis_out_tuser_o,
    output logic              m_axis_out_tlast_o,
    output logic              m_axis_out_tvalid_o,
    output logic              symbol_start_o,
    output logic              ssb_start_o
);

    pss_mode_e              pss_state_q;
    logic [TMR_W-1:0]       clks_q;
    sync_state_e            state_q;
    logic [IN_DW-1:0]       tdata_q;
    logic                   vld_q;
    logic [SFN_W-1:0]       sfn_q, nxt_sfn;
    logic [SF_W-1:0]        sf_q, nxt_sf;
    logic [SYM_W-1:0]       sym_q, nxt_sym;
    logic [SMP_W-1:0]       smp_q, nxt_smp;
    logic [SMP_W-1:0]       sym_len;
    logic [SSB_CNT_W-1:0]   syms_q;
    logic                   find_q;
    logic                   last_smp, chk_open, ssb_hit, ssb_miss, out_valid;

    // symbols 0 and 7 carry the long CP
    function automatic logic [CP_W-1:0] cp_len(input logic [SYM_W-1:0] sym);
        return ((sym == '0) || (sym == SYM_W'(SYM_PER_SF / 2))) ? CP_W'(CP1_LEN) : CP_W'(CP2_LEN);
    endfunction

    // the data path is a plain two-stage delay
    always_ff @(posedge clk_i) begin
        tdata_q <= s_axis_in_tdata_i;
        m_axis_out_tdata_o <= tdata_q;
    end

    // PSS detector mode: pause for a frame, wake up early, give up a little late
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pss_state_q <= PSS_SEARCH;
            clks_q <= '0;
            ctrl_o.mode <= PSS_SEARCH;
            ctrl_o.req_nid2 <= '0;
        end else begin
            ctrl_o.mode <= pss_state_q;
            if (n_id_2_valid_i) begin
                ctrl_o.req_nid2 <= n_id_2_i;
            end
            case (pss_state_q)
                PSS_SEARCH: begin
                    if (n_id_2_valid_i) begin
                        pss_state_q <= PSS_PAUSE;
                        clks_q <= TMR_W'(1);
                    end
                end
                PSS_PAUSE: begin
                    clks_q <= clks_q + 1'b1;
                    if (clks_q >= TMR_W'(FRAME_SAMPLES - PSS_EARLY)) begin
                        pss_state_q <= PSS_FIND;
                    end
                end
                PSS_FIND: begin
                    if (n_id_2_valid_i) begin
                        pss_state_q <= PSS_PAUSE;
                        clks_q <= TMR_W'(1);
                    end else if (clks_q >= TMR_W'(FRAME_SAMPLES + PSS_LATE)) begin
                        pss_state_q <= PSS_SEARCH;
                    end else begin
                        clks_q <= clks_q + 1'b1;
                    end
                end
                default: pss_state_q <= PSS_SEARCH;
            endcase
        end
    end

    // the counters hold the position of the sample leaving on the next valid edge
    always_comb begin
        sym_len = SMP_W'(FFT_LEN) + SMP_W'(cp_len(sym_q));
        last_smp = (smp_q == sym_len - 1'b1);
        nxt_smp = smp_q;
        nxt_sym = sym_q;
        nxt_sf = sf_q;
        nxt_sfn = sfn_q;
        if (vld_q) begin
            nxt_smp = last_smp ? '0 : smp_q + 1'b1;
            if (last_smp && (sym_q == SYM_W'(SYM_PER_SF - 1))) begin
                nxt_sym = '0;
                if (sf_q == SF_W'(SUBFRAMES_PER_FRAME - 1)) begin
                    nxt_sf = '0;
                    nxt_sfn = (sfn_q == SFN_W'(SFN_MAX - 1)) ? '0 : sfn_q + 1'b1;
                end else begin
                    nxt_sf = sf_q + 1'b1;
                end
            end else if (last_smp) begin
                nxt_sym = sym_q + 1'b1;
            end
        end
        // ibar_SSB tells which of the four case-A SSBs was caught
        if ((state_q == WAIT_FOR_IBAR) && ibar_ssb_valid_i) begin
            if ((ibar_ssb_i == 3'd1) || (ibar_ssb_i == 3'd3)) begin
                nxt_sym = (32'(nxt_sym) + 6 >= SYM_PER_SF) ? SYM_W'(32'(nxt_sym) + 6 - SYM_PER_SF)
                                                           : SYM_W'(32'(nxt_sym) + 6);
            end
            if ((ibar_ssb_i == 3'd2) || (ibar_ssb_i == 3'd3)) begin
                nxt_sf = (nxt_sf == SF_W'(SUBFRAMES_PER_FRAME - 1)) ? '0 : nxt_sf + 1'b1;
            end
        end
    end

    // the SSB check opens on the last sample before the next expected SSB symbol
    assign chk_open = (state_q == SYNCED) && !find_q && vld_q && last_smp &&
                      (syms_q == SSB_CNT_W'(SYMS_BTWN_SSB - 1));
    assign ssb_hit = (state_q == SYNCED) && find_q && n_id_2_valid_i;
    assign ssb_miss = (state_q == SYNCED) && find_q && !n_id_2_valid_i && vld_q &&
                      (smp_q == SMP_W'(SSB_MISS_SMP));
    assign out_valid = vld_q && !chk_open && (!find_q || n_id_2_valid_i);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q <= WAIT_FOR_SSB;
            vld_q <= 1'b0;
            sfn_q <= '0;
            sf_q <= '0;
            sym_q <= '0;
            smp_q <= '0;
            syms_q <= '0;
            find_q <= 1'b0;
            m_axis_out_tvalid_o <= 1'b0;
            m_axis_out_tlast_o <= 1'b0;
            symbol_start_o <= 1'b0;
            ssb_start_o <= 1'b0;
        end else begin
            vld_q <= s_axis_in_tvalid_i;
            ssb_start_o <= 1'b0;
            symbol_start_o <= 1'b0;
            m_axis_out_tlast_o <= 1'b0;
            case (state_q)
                WAIT_FOR_SSB: begin
                    m_axis_out_tvalid_o <= 1'b0;
                    find_q <= 1'b0;
                    if (n_id_2_valid_i) begin
                        // assume symbol 3 of subframe 0 until ibar_SSB says otherwise
                        state_q <= WAIT_FOR_IBAR;
                        sfn_q <= '0;
                        sf_q <= '0;
                        sym_q <= SYM_W'(PSS_SYM);
                        smp_q <= SMP_W'(1);
                        syms_q <= '0;
                        m_axis_out_tvalid_o <= 1'b1;
                        m_axis_out_tuser_o <= {SFN_W'(0), SF_W'(0), SYM_W'(PSS_SYM),
                                               cp_len(SYM_W'(PSS_SYM))};
                        symbol_start_o <= 1'b1;
                        ssb_start_o <= 1'b1;
                    end
                end
                default: begin
                    sfn_q <= nxt_sfn;
                    sf_q <= nxt_sf;
                    sym_q <= nxt_sym;
                    smp_q <= nxt_smp;
                    if (ssb_hit) begin
                        syms_q <= '0;
                    end else if (vld_q && last_smp) begin
                        syms_q <= syms_q + 1'b1;
                    end
                    if (vld_q) begin
                        m_axis_out_tuser_o <= {sfn_q, sf_q, sym_q, cp_len(sym_q)};
                    end
                    m_axis_out_tvalid_o <= out_valid;
                    m_axis_out_tlast_o <= out_valid && last_smp;
                    symbol_start_o <= out_valid && (smp_q == '0);
                    ssb_start_o <= ssb_hit;
                    if (chk_open) begin
                        find_q <= 1'b1;
                    end else if (ssb_hit) begin
                        find_q <= 1'b0;
                    end
                    if ((state_q == WAIT_FOR_IBAR) && ibar_ssb_valid_i) begin
                        state_q <= SYNCED;
                    end
                    // SSB did not show up, so the timing is lost
                    if (ssb_miss) begin
                        state_q <= WAIT_FOR_SSB;
                        find_q <= 1'b0;
                    end
                end
            endcase
        end
    end

    // every valid output sample carries one of the two CP lengths
    cp_len_legal: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o |-> (m_axis_out_tuser_o[CP_W-1:0] inside {CP_W'(CP1_LEN), CP_W'(CP2_LEN)})
    );

endmodule

// ==== src/cell_search_top.sv ====
`timescale 1ns/1ps

module cell_search_top import sync_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_ni,
    input  logic [IN_DW-1:0]  s_axis_in_tdata_i,
    input  logic              s_axis_in_tvalid_i,
    input  logic [2:0]        ibar_ssb_i,
    input  logic              ibar_ssb_valid_i,
    output pss_mode_e         pss_detector_mode_o,
    output logic [1:0]        requested_n_id_2_o,
    output logic [1:0]        n_id_2_o,
    output logic              n_id_2_valid_o,
    output logic [IN_DW-1:0]  m_axis_out_tdata_o,
    output logic [USER_W-1:0] m_axis_out_tuser_o,
    output logic              m_axis_out_tlast_o,
    output logic              m_axis_out_tvalid_o,
    output logic              symbol_start_o,
    output logic              ssb_start_o
);

    pss_metric_if metric_bus ();

    logic [PSS_LEN-1:0]  win;
    logic [METRIC_W-1:0] metric [NUM_NID2];

    sample_window sample_window_inst (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .s_axis_in_tdata_i  (s_axis_in_tdata_i),
        .s_axis_in_tvalid_i (s_axis_in_tvalid_i),
        .win_o              (win),
        .bus_o              (metric_bus.window)
    );

    // one matcher per N_id_2, all looking at the same window
    for (genvar g = 0; g < NUM_NID2; g++) begin : g_matcher
        pss_matcher #(
            .NID2 (g)
        ) pss_matcher_inst (
            .clk_i    (clk_i),
            .reset_ni (reset_ni),
            .win_i    (win),
            .metric_o (metric[g])
        );

        assign metric_bus.metric[g] = metric[g];
    end

    pss_peak_select pss_peak_select_inst (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .bus_i          (metric_bus.select),
        .n_id_2_o       (n_id_2_o),
        .n_id_2_valid_o (n_id_2_valid_o)
    );

    frame_sync frame_sync_inst (
        .clk_i               (clk_i),
        .reset_ni            (reset_ni),
        .s_axis_in_tdata_i   (s_axis_in_tdata_i),
        .s_axis_in_tvalid_i  (s_axis_in_tvalid_i),
        .n_id_2_i            (n_id_2_o),
        .n_id_2_valid_i      (n_id_2_valid_o),
        .ibar_ssb_i          (ibar_ssb_i),
        .ibar_ssb_valid_i    (ibar_ssb_valid_i),
        .ctrl_o              (metric_bus.control),
        .m_axis_out_tdata_o  (m_axis_out_tdata_o),
        .m_axis_out_tuser_o  (m_axis_out_tuser_o),
        .m_axis_out_tlast_o  (m_axis_out_tlast_o),
        .m_axis_out_tvalid_o (m_axis_out_tvalid_o),
        .symbol_start_o      (symbol_start_o),
        .ssb_start_o         (ssb_start_o)
    );

    assign pss_detector_mode_o = metric_bus.mode;
    assign requested_n_id_2_o = metric_bus.req_nid2;

endmodule

// ==== tb/cell_search_tb.sv ====
`timescale 1ns/1ps

module cell_search_tb import sync_pkg::*; ();

    // last-sample index of each inserted PSS, its N_id_2, and whether the DUT should report it
    localparam int L1 = 300;
    localparam int L4 = L1 + 2 * FRAME_SAMPLES + 800;
    localparam int NUM_SAMPLES = L4 + 3000;
    localparam int NUM_PAT = 4;
    localparam int PAT_END [NUM_PAT] = '{L1, L1 + FRAME_SAMPLES, L1 + 2 * FRAME_SAMPLES, L4};
    localparam int PAT_ID [NUM_PAT] = '{2, 2, 0, 1};
    localparam bit PAT_DET [NUM_PAT] = '{1'b1, 1'b1, 1'b0, 1'b1};

    logic              clk_i;
    logic              reset_ni;
    logic [IN_DW-1:0]  s_axis_in_tdata_i;
    logic              s_axis_in_tvalid_i;
    logic [2:0]        ibar_ssb_i;
    logic              ibar_ssb_valid_i;
    pss_mode_e         pss_detector_mode_o;
    logic [1:0]        requested_n_id_2_o;
    logic [1:0]        n_id_2_o;
    logic              n_id_2_valid_o;
    logic [IN_DW-1:0]  m_axis_out_tdata_o;
    logic [USER_W-1:0] m_axis_out_tuser_o;
    logic              m_axis_out_tlast_o;
    logic              m_axis_out_tvalid_o;
    logic              symbol_start_o;
    logic              ssb_start_o;

    logic [IN_DW-1:0] samples [NUM_SAMPLES];
    bit               sgn [NUM_SAMPLES];
    bit               fixed [NUM_SAMPLES];
    int               k_cur = -1;

    cell_search_top cell_search_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run;
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_tuser(input logic [USER_W-1:0] exp, input logic [USER_W-1:0] act);
        if (act !== exp) begin
            $display("Error: m_axis_out_tuser_o expected 0x%h, got 0x%h", exp, act);
            abort_run();
        end
    endtask

    task automatic check_tdata(input logic [IN_DW-1:0] exp, input logic [IN_DW-1:0] act);
        if (act !== exp) begin
            $display("Error: m_axis_out_tdata_o expected 0x%h, got 0x%h", exp, act);
            abort_run();
        end
    endtask

    task automatic check_nid2(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mode(input pss_mode_e exp, input pss_mode_e act);
        if (act !== exp) begin
            $display("Error: pss_detector_mode_o expected 0x%h, got 0x%h", exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // best agreement of the 16-sample window ending at sample e with any pattern
    function automatic int window_score(input int e);
        logic [PSS_LEN-1:0] w;
        int idx;
        int n;
        int best;
        best = 0;
        for (int i = 0; i < PSS_LEN; i++) begin
            idx = e - PSS_LEN + 1 + i;
            w[PSS_LEN-1-i] = (idx >= 0) ? sgn[idx] : 1'b0;
        end
        for (int p = 0; p < NUM_NID2; p++) begin
            n = $countones(~(w ^ PSS_PATTERN[p]));
            if (n > best) best = n;
        end
        return best;
    endfunction

    // sample j is the last free bit of every window scored here
    function automatic int choice_score(input int j);
        int e;
        int s;
        int best;
        best = 0;
        e = j;
        while ((e < NUM_SAMPLES) && (e < j + PSS_LEN) && ((e == j) || fixed[e])) begin
            s = window_score(e);
            if (s > best) best = s;
            e++;
        end
        return best;
    endfunction

    task automatic build_stimulus;
        logic [31:0] st;
        int s0;
        int s1;
        int pos;
        st = 32'h2a68_7274;
        for (int p = 0; p < NUM_PAT; p++) begin
            for (int i = 0; i < PSS_LEN; i++) begin
                pos = PAT_END[p] - PSS_LEN + 1 + i;
                sgn[pos] = PSS_PATTERN[PAT_ID[p]][PSS_LEN-1-i];
                fixed[pos] = 1'b1;
            end
        end
        for (int j = 0; j < NUM_SAMPLES; j++) begin
            if (!fixed[j]) begin
                // pick the sign that keeps every window furthest from all patterns
                sgn[j] = 1'b0;
                s0 = choice_score(j);
                sgn[j] = 1'b1;
                s1 = choice_score(j);
                if (s0 < s1) sgn[j] = 1'b0;
                if (((s0 < s1) ? s0 : s1) >= PSS_THRESHOLD) begin
                    $display("random stimulus could not avoid a false PSS match at sample %0d", j);
                    abort_run();
                end
            end
            st = lcg_next(st);
            samples[j] = {st[31:16], sgn[j], st[14:0]};
        end
    endtask

    function automatic int sym_offset(input int sym);
        if (sym == 0) return 0;
        if (sym <= SYM_PER_SF / 2) return (FFT_LEN + CP1_LEN) + (sym - 1) * (FFT_LEN + CP2_LEN);
        return 2 * (FFT_LEN + CP1_LEN) + (sym - 2) * (FFT_LEN + CP2_LEN);
    endfunction

    // expected tuser for output sample n after sync
    // the ibar shift shows from sample 2 on
    function automatic void ref_position(input int n, input int ibar,
                                         output logic [USER_W-1:0] tuser,
                                         output bit first, output bit last);
        int sym0;
        int sf0;
        int q;
        int sft;
        int r;
        int sym;
        int off;
        int cp;
        sym0 = PSS_SYM;
        sf0 = 0;
        if ((n >= 2) && ((ibar == 1) || (ibar == 3))) sym0 = sym0 + 6;
        if ((n >= 2) && ((ibar == 2) || (ibar == 3))) sf0 = sf0 + 1;
        q = sf0 * SF_SAMPLES + sym_offset(sym0) + n;
        sft = q / SF_SAMPLES;
        r = q % SF_SAMPLES;
        sym = 0;
        while ((sym < SYM_PER_SF - 1) && (sym_offset(sym + 1) <= r)) sym++;
        off = r - sym_offset(sym);
        cp = ((sym == 0) || (sym == SYM_PER_SF / 2)) ? CP1_LEN : CP2_LEN;
        tuser = {SFN_W'((sft / SUBFRAMES_PER_FRAME) % SFN_MAX), SF_W'(sft % SUBFRAMES_PER_FRAME),
                 SYM_W'(sym), CP_W'(cp)};
        first = (off == 0);
        last = (off == FFT_LEN + cp - 1);
    endfunction

    initial begin
        reset_ni = 1'b0;
        s_axis_in_tdata_i = '0;
        s_axis_in_tvalid_i = 1'b0;
        ibar_ssb_i = '0;
        ibar_ssb_valid_i = 1'b0;
        build_stimulus();
        repeat (3) @(posedge clk_i);
        reset_ni <= 1'b1;
        for (int k = 0; k < NUM_SAMPLES; k++) begin
            @(posedge clk_i);
            k_cur = k;
            s_axis_in_tdata_i <= samples[k];
            s_axis_in_tvalid_i <= 1'b1;
            ibar_ssb_i <= (k < L4) ? 3'd3 : 3'd0;
            // ibar_SSB arrives while the DUT sits in WAIT_FOR_IBAR
            ibar_ssb_valid_i <= (k == L1 + 4) || (k == L4 + 4);
        end
        @(posedge clk_i);
        $display("SIMULATION PASSED");
        $finish;
    end

    always @(negedge clk_i) begin
        int k;
        int n;
        int ibar;
        logic [USER_W-1:0] exp_user;
        logic [1:0] exp_id;
        bit first;
        bit last;
        bit exp_valid;
        bit exp_ssb;
        bit exp_det;
        if (k_cur >= 0) begin
            k = k_cur;
            if (k >= L4 + 4) begin
                n = k - (L4 + 4);
                ibar = 0;
                exp_valid = 1'b1;
                exp_ssb = (n == 0);
            end else begin
                n = k - (L1 + 4);
                ibar = 3;
                // one sample gap at the frame check and no output once the SSB goes missing
                exp_valid = (n >= 0) && (n < 2 * FRAME_SAMPLES - 1) && (n != FRAME_SAMPLES - 1);
                exp_ssb = (n == 0) || (n == FRAME_SAMPLES);
            end
            exp_det = 1'b0;
            exp_id = 2'd0;
            for (int p = 0; p < NUM_PAT; p++) begin
                if (PAT_DET[p] && (k == PAT_END[p] + 3)) begin
                    exp_det = 1'b1;
                    exp_id = 2'(PAT_ID[p]);
                end
            end
            ref_position((n < 0) ? 0 : n, ibar, exp_user, first, last);
            check_flag("m_axis_out_tvalid_o", exp_valid, m_axis_out_tvalid_o);
            check_flag("ssb_start_o", exp_ssb, ssb_start_o);
            check_flag("n_id_2_valid_o", exp_det, n_id_2_valid_o);
            check_flag("m_axis_out_tlast_o", exp_valid && last, m_axis_out_tlast_o);
            check_flag("symbol_start_o", exp_valid && first, symbol_start_o);
            if (exp_det) check_nid2("n_id_2_o", exp_id, n_id_2_o);
            if (exp_valid) begin
                check_tuser(exp_user, m_axis_out_tuser_o);
                check_tdata(samples[k-2], m_axis_out_tdata_o);
            end
            if (k == 50) check_mode(PSS_SEARCH, pss_detector_mode_o);
            if (n == 100) begin
                check_mode(PSS_PAUSE, pss_detector_mode_o);
                check_nid2("requested_n_id_2_o", (k < L4) ? 2'd2 : 2'd1, requested_n_id_2_o);
            end
            if (k < L4 + 4) begin
                if (n == FRAME_SAMPLES - 4) check_mode(PSS_FIND, pss_detector_mode_o);
                if (n == FRAME_SAMPLES + 80) check_mode(PSS_PAUSE, pss_detector_mode_o);
                if (n == 2 * FRAME_SAMPLES) check_mode(PSS_FIND, pss_detector_mode_o);
                if (n == 2 * FRAME_SAMPLES + 60) check_mode(PSS_SEARCH, pss_detector_mode_o);
            end
        end
    end

    // watchdog sized from the stimulus length
    initial begin
        #((NUM_SAMPLES + 1000) * 100);
        $display("watchdog expired before the stimulus finished");
        abort_run();
    end

endmodule

// ==== cell_search_top.f ====
src/sync_pkg.sv
src/pss_metric_if.sv
src/sample_window.sv
src/pss_matcher.sv
src/pss_peak_select.sv
src/frame_sync.sv
src/cell_search_top.sv
tb/cell_search_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= cell_search_tb
FILELIST  ?= cell_search_top.f
LOG       ?= sim.log

BIN = obj_dir/V$(TOP)

.PHONY: compile run clean

compile: $(BIN)

$(BIN): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
